//--- verilog/mcu_pkg.sv
/*
 * Shared types, address map and register offsets for the MCU bus skeleton.
 * Every RTL module pulls these in through a wildcard import.
 */
package mcu_pkg;

  localparam int NUM_BANKS     = 2;
  localparam int BANK_WORDS    = 256;
  localparam int NUM_GPIO      = 32;
  localparam int NUM_GPIO_INTR = 8;

  typedef logic [31:0]                   addr_t;
  typedef logic [31:0]                   data_t;
  typedef logic [3:0]                    be_t;
  typedef logic [$clog2(BANK_WORDS)-1:0] word_idx_t;
  typedef logic [NUM_GPIO-1:0]           gpio_vec_t;
  typedef logic [NUM_GPIO_INTR-1:0]      intr_vec_t;

  // address map, ram bank picked by addr[10]
  localparam addr_t RAM_START   = 32'h0000_0000;
  localparam addr_t AO_START    = 32'h2000_0000;
  localparam addr_t GPIO_START  = 32'h3000_0000;
  localparam addr_t PERIPH_SPAN = 32'h0000_1000;

  // always-on block registers
  localparam addr_t EXIT_VALID_OFF   = 32'h0;
  localparam addr_t EXIT_VALUE_OFF   = 32'h4;
  localparam addr_t INTR_PENDING_OFF = 32'h8;
  localparam addr_t INTR_ENABLE_OFF  = 32'hC;

  // gpio registers
  localparam addr_t GPIO_IN_OFF      = 32'h0;
  localparam addr_t GPIO_OUT_OFF     = 32'h4;
  localparam addr_t GPIO_OE_OFF      = 32'h8;
  localparam addr_t GPIO_INTR_EN_OFF = 32'hC;

  localparam data_t UNMAPPED_RDATA = 32'hBADC_AB1E;

  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic      valid;
    logic      we;
    be_t       be;
    word_idx_t offset;
    data_t     wdata;
  } tgt_req_t;

  typedef enum logic [2:0] {
    SEL_RAM0,
    SEL_RAM1,
    SEL_AO,
    SEL_GPIO,
    SEL_NONE
  } tgt_sel_e;

  // byte offset of a register to the word index a target sees
  function automatic word_idx_t reg_word(input addr_t off);
    return off[2 +: $bits(word_idx_t)];
  endfunction

endpackage

//--- verilog/system_bus.sv
/*
 * Single-master system bus. Decodes the address, forwards the request to one
 * target and returns the response one cycle after acceptance.
 */
`timescale 1ns/1ps

module system_bus
  import mcu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  bus_req_t                 master_req_i,
  output bus_rsp_t                 master_rsp_o,
  output tgt_req_t [NUM_BANKS-1:0] ram_req_o,
  input  data_t    [NUM_BANKS-1:0] ram_rdata_i,
  output tgt_req_t                 ao_req_o,
  input  data_t                    ao_rdata_i,
  output tgt_req_t                 gpio_req_o,
  input  data_t                    gpio_rdata_i
);

  logic     gnt_q;
  logic     accept;
  logic     valid_q;
  logic     we_q;
  tgt_sel_e sel;
  tgt_sel_e sel_q;
  data_t    rdata;

  function automatic tgt_req_t fwd(input logic hit, input bus_req_t r);
    tgt_req_t t;
    t.valid  = hit;
    t.we     = r.we;
    t.be     = r.be;
    t.offset = r.addr[2 +: $bits(word_idx_t)];
    t.wdata  = r.wdata;
    return t;
  endfunction

  assign accept = master_req_i.req && gnt_q;

  always_comb begin
    sel = SEL_NONE;
    if ((master_req_i.addr - RAM_START) < addr_t'(NUM_BANKS * BANK_WORDS * 4)) begin
      // bank select sits right above the word index
      sel = master_req_i.addr[10] ? SEL_RAM1 : SEL_RAM0;
    end else if ((master_req_i.addr - AO_START) < PERIPH_SPAN) begin
      sel = SEL_AO;
    end else if ((master_req_i.addr - GPIO_START) < PERIPH_SPAN) begin
      sel = SEL_GPIO;
    end
  end

  assign ram_req_o[0] = fwd(accept && (sel == SEL_RAM0), master_req_i);
  assign ram_req_o[1] = fwd(accept && (sel == SEL_RAM1), master_req_i);
  assign ao_req_o     = fwd(accept && (sel == SEL_AO), master_req_i);
  assign gpio_req_o   = fwd(accept && (sel == SEL_GPIO), master_req_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gnt_q   <= 1'b0;
      valid_q <= 1'b0;
      we_q    <= 1'b0;
      sel_q   <= SEL_NONE;
    end else begin
      gnt_q   <= 1'b1;
      valid_q <= accept;
      if (accept) begin
        we_q  <= master_req_i.we;
        sel_q <= sel;
      end
    end
  end

  // writes answer with zero data
  always_comb begin
    rdata = '0;
    if (valid_q && !we_q) begin
      unique case (sel_q)
        SEL_RAM0: rdata = ram_rdata_i[0];
        SEL_RAM1: rdata = ram_rdata_i[1];
        SEL_AO:   rdata = ao_rdata_i;
        SEL_GPIO: rdata = gpio_rdata_i;
        default:  rdata = UNMAPPED_RDATA;
      endcase
    end
  end

  assign master_rsp_o.gnt    = gnt_q;
  assign master_rsp_o.rvalid = valid_q;
  assign master_rsp_o.err    = valid_q && (sel_q == SEL_NONE);
  assign master_rsp_o.rdata  = rdata;

  // responses follow an accepted request and flag err when no target took it
  assert property (@(posedge clk_i) disable iff (rst_i)
    master_rsp_o.rvalid |-> $past(accept) && (master_rsp_o.err ==
      !$past(ram_req_o[0].valid || ram_req_o[1].valid || ao_req_o.valid ||
             gpio_req_o.valid)));

endmodule

//--- verilog/memory_subsystem.sv
/*
 * Two single-port RAM banks behind the system bus.
 * Writes honor byte enables, reads return one cycle later.
 */
`timescale 1ns/1ps

module memory_subsystem
  import mcu_pkg::*;
(
  input  logic                     clk_i,
  input  tgt_req_t [NUM_BANKS-1:0] ram_req_i,
  output data_t    [NUM_BANKS-1:0] ram_rdata_o
);

  logic [NUM_BANKS-1:0] bank_valid;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    data_t mem [BANK_WORDS];
    data_t rdata_q;

    always_ff @(posedge clk_i) begin
      if (ram_req_i[b].valid) begin
        if (ram_req_i[b].we) begin
          for (int i = 0; i < $bits(be_t); i++) begin
            if (ram_req_i[b].be[i]) begin
              mem[ram_req_i[b].offset][8*i +: 8] <= ram_req_i[b].wdata[8*i +: 8];
            end
          end
        end else begin
          rdata_q <= mem[ram_req_i[b].offset];
        end
      end
    end

    assign ram_rdata_o[b] = rdata_q;
    assign bank_valid[b]  = ram_req_i[b].valid;
  end

  // the decoder hands each access to a single bank
  assert property (@(posedge clk_i) $onehot0(bank_valid));

endmodule

//--- verilog/ao_peripheral_subsystem.sv
/*
 * Always-on block: exit registers and the fast interrupt collector.
 * GPIO events latch into pending and irq_fast_o flags any enabled pending bit.
 */
`timescale 1ns/1ps

module ao_peripheral_subsystem
  import mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  tgt_req_t  req_i,
  output data_t     rdata_o,
  input  intr_vec_t gpio_intr_i,
  output logic      exit_valid_o,
  output data_t     exit_value_o,
  output logic      irq_fast_o
);

  logic      exit_valid_q;
  data_t     exit_value_q;
  intr_vec_t pending_q;
  intr_vec_t enable_q;
  intr_vec_t pending_clr;
  data_t     rdata_q;
  logic      wr;

  assign wr = req_i.valid && req_i.we;

  // write-one-to-clear that loses to a new event in the same cycle
  assign pending_clr = (wr && req_i.offset == reg_word(INTR_PENDING_OFF)) ?
                       req_i.wdata[NUM_GPIO_INTR-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      pending_q    <= '0;
      enable_q     <= '0;
    end else begin
      pending_q <= (pending_q & ~pending_clr) | gpio_intr_i;
      if (wr) begin
        if (req_i.offset == reg_word(EXIT_VALID_OFF)) begin
          exit_valid_q <= req_i.wdata[0];
        end
        if (req_i.offset == reg_word(EXIT_VALUE_OFF)) begin
          exit_value_q <= req_i.wdata;
        end
        if (req_i.offset == reg_word(INTR_ENABLE_OFF)) begin
          enable_q <= req_i.wdata[NUM_GPIO_INTR-1:0];
        end
      end
    end
  end

  // unknown offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req_i.valid && !req_i.we) begin
      unique case (req_i.offset)
        reg_word(EXIT_VALID_OFF):   rdata_q <= data_t'(exit_valid_q);
        reg_word(EXIT_VALUE_OFF):   rdata_q <= exit_value_q;
        reg_word(INTR_PENDING_OFF): rdata_q <= data_t'(pending_q);
        reg_word(INTR_ENABLE_OFF):  rdata_q <= data_t'(enable_q);
        default:                    rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o      = rdata_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;
  assign irq_fast_o   = |(pending_q & enable_q);

  // a cleared enable with no enable write keeps the line low next cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    (enable_q == '0) && !(wr && req_i.offset == reg_word(INTR_ENABLE_OFF))
      |=> !irq_fast_o);

endmodule

//--- verilog/gpio.sv
/*
 * 32-pin GPIO with output and output-enable registers, synchronized inputs
 * and rising-edge interrupt events on the low pins.
 */
`timescale 1ns/1ps

module gpio
  import mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  tgt_req_t  req_i,
  output data_t     rdata_o,
  input  gpio_vec_t gpio_i,
  output gpio_vec_t gpio_o,
  output gpio_vec_t gpio_oe_o,
  output intr_vec_t gpio_intr_o
);

  gpio_vec_t out_q;
  gpio_vec_t oe_q;
  intr_vec_t intr_en_q;
  gpio_vec_t sync1_q;
  gpio_vec_t sync2_q;
  intr_vec_t prev_q;
  data_t     rdata_q;
  logic      wr;

  assign wr = req_i.valid && req_i.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
    end else begin
      // two-flop synchronizer and history for edge detect
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q[NUM_GPIO_INTR-1:0];
      if (wr && req_i.offset == reg_word(GPIO_OUT_OFF)) begin
        out_q <= req_i.wdata;
      end
      if (wr && req_i.offset == reg_word(GPIO_OE_OFF)) begin
        oe_q <= req_i.wdata;
      end
      if (wr && req_i.offset == reg_word(GPIO_INTR_EN_OFF)) begin
        intr_en_q <= req_i.wdata[NUM_GPIO_INTR-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid && !req_i.we) begin
      unique case (req_i.offset)
        reg_word(GPIO_IN_OFF):      rdata_q <= sync2_q;
        reg_word(GPIO_OUT_OFF):     rdata_q <= out_q;
        reg_word(GPIO_OE_OFF):      rdata_q <= oe_q;
        reg_word(GPIO_INTR_EN_OFF): rdata_q <= data_t'(intr_en_q);
        default:                    rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o     = rdata_q;
  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_intr_o = sync2_q[NUM_GPIO_INTR-1:0] & ~prev_q & intr_en_q;

  // events need an enabled pin that was low on the cycle before
  assert property (@(posedge clk_i) disable iff (rst_i)
    (gpio_intr_o & ~(intr_en_q & ~$past(sync2_q[NUM_GPIO_INTR-1:0]))) == '0);

endmodule

//--- verilog/mcu_top.sv
/*
 * Top level of the bus skeleton: one external master reaches RAM, the
 * always-on block and GPIO through the system bus.
 */
`timescale 1ns/1ps

module mcu_top
  import mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  bus_req_t  master_req_i,
  output bus_rsp_t  master_rsp_o,
  input  gpio_vec_t gpio_i,
  output gpio_vec_t gpio_o,
  output gpio_vec_t gpio_oe_o,
  output logic      exit_valid_o,
  output data_t     exit_value_o,
  output logic      irq_fast_o
);

  tgt_req_t [NUM_BANKS-1:0] ram_req;
  data_t    [NUM_BANKS-1:0] ram_rdata;
  tgt_req_t                 ao_req;
  data_t                    ao_rdata;
  tgt_req_t                 gpio_req;
  data_t                    gpio_rdata;
  intr_vec_t                gpio_intr;

  system_bus system_bus_i (
    .clk_i,
    .rst_i,
    .master_req_i,
    .master_rsp_o,
    .ram_req_o   (ram_req),
    .ram_rdata_i (ram_rdata),
    .ao_req_o    (ao_req),
    .ao_rdata_i  (ao_rdata),
    .gpio_req_o  (gpio_req),
    .gpio_rdata_i(gpio_rdata)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i,
    .ram_req_i  (ram_req),
    .ram_rdata_o(ram_rdata)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i,
    .rst_i,
    .req_i      (ao_req),
    .rdata_o    (ao_rdata),
    .gpio_intr_i(gpio_intr),
    .exit_valid_o,
    .exit_value_o,
    .irq_fast_o
  );

  gpio gpio_i0 (
    .clk_i,
    .rst_i,
    .req_i      (gpio_req),
    .rdata_o    (gpio_rdata),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o(gpio_intr)
  );

endmodule

//--- test/tb_mcu.sv
/*
 * Random-stimulus testbench for the MCU bus skeleton. Drives the master port
 * and GPIO pins, checks every response and output against a model kept here.
 */
`timescale 1ns/1ps

module tb_mcu
  import mcu_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int RAM_WORDS   = NUM_BANKS * BANK_WORDS;
  localparam int RAM_OPS     = 300;
  localparam int GPIO_ROUNDS = 30;
  localparam int IRQ_ROUNDS  = 24;
  localparam int EXIT_ROUNDS = 8;
  localparam int UNMAP_OPS   = 40;
  // cycles per round of each test, idle cycles and drain included
  localparam int RUN_CYCLES  = 20 + RAM_WORDS + RAM_OPS + GPIO_ROUNDS * 9 + IRQ_ROUNDS * 18 +
                               EXIT_ROUNDS * 6 + UNMAP_OPS + 20 + 6 * 6;

  localparam int REG_RAM  = 0;
  localparam int REG_AO   = 1;
  localparam int REG_GPIO = 2;
  localparam int REG_NONE = 3;

  logic      clk;
  logic      rst;
  bus_req_t  master_req;
  bus_rsp_t  master_rsp;
  gpio_vec_t gpio_in;
  gpio_vec_t gpio_out;
  gpio_vec_t gpio_oe;
  logic      exit_valid;
  data_t     exit_value;
  logic      irq_fast;

  // model state
  data_t     ram_m [RAM_WORDS];
  logic      exit_valid_m;
  data_t     exit_value_m;
  intr_vec_t pend_m;
  intr_vec_t en_m;
  intr_vec_t gpio_ien_m;
  gpio_vec_t out_m;
  gpio_vec_t oe_m;
  gpio_vec_t pins_m;

  // responses still owed by the DUT, oldest first
  data_t exp_data_q [$];
  logic  exp_err_q [$];
  string exp_name_q [$];

  string test_name;
  int    errors;
  int    checks;
  int    errs_at_start;
  int    tests_run;
  int    tests_failed;
  logic  accept_prev;
  data_t got_exp;
  logic  got_err;
  string got_name;

  mcu_top dut0 (
    .clk_i       (clk),
    .rst_i       (rst),
    .master_req_i(master_req),
    .master_rsp_o(master_rsp),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value),
    .irq_fast_o  (irq_fast)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int region_of(input addr_t a);
    if ((a - RAM_START) < addr_t'(RAM_WORDS * 4))
      return REG_RAM;
    if ((a - AO_START) < PERIPH_SPAN)
      return REG_AO;
    if ((a - GPIO_START) < PERIPH_SPAN)
      return REG_GPIO;
    return REG_NONE;
  endfunction

  // registers take the whole word, only RAM looks at byte enables
  function automatic void model_write(input addr_t a, input data_t d, input be_t be);
    int    w;
    addr_t off;
    case (region_of(a))
      REG_RAM: begin
        w = int'((a - RAM_START) >> 2);
        for (int i = 0; i < 4; i++) begin
          if (be[i])
            ram_m[w][8*i +: 8] = d[8*i +: 8];
        end
      end
      REG_AO: begin
        off = a - AO_START;
        if (off == EXIT_VALID_OFF)
          exit_valid_m = d[0];
        if (off == EXIT_VALUE_OFF)
          exit_value_m = d;
        if (off == INTR_PENDING_OFF)
          pend_m = pend_m & ~intr_vec_t'(d);
        if (off == INTR_ENABLE_OFF)
          en_m = intr_vec_t'(d);
      end
      REG_GPIO: begin
        off = a - GPIO_START;
        if (off == GPIO_OUT_OFF)
          out_m = d;
        if (off == GPIO_OE_OFF)
          oe_m = d;
        if (off == GPIO_INTR_EN_OFF)
          gpio_ien_m = intr_vec_t'(d);
      end
      default: ;
    endcase
  endfunction

  function automatic data_t model_read(input addr_t a);
    data_t d;
    addr_t off;
    d = '0;
    case (region_of(a))
      REG_RAM:  d = ram_m[int'((a - RAM_START) >> 2)];
      REG_AO: begin
        off = a - AO_START;
        if (off == EXIT_VALID_OFF)
          d = data_t'(exit_valid_m);
        if (off == EXIT_VALUE_OFF)
          d = exit_value_m;
        if (off == INTR_PENDING_OFF)
          d = data_t'(pend_m);
        if (off == INTR_ENABLE_OFF)
          d = data_t'(en_m);
      end
      REG_GPIO: begin
        off = a - GPIO_START;
        if (off == GPIO_IN_OFF)
          d = pins_m;
        if (off == GPIO_OUT_OFF)
          d = out_m;
        if (off == GPIO_OE_OFF)
          d = oe_m;
        if (off == GPIO_INTR_EN_OFF)
          d = data_t'(gpio_ien_m);
      end
      default:  d = UNMAPPED_RDATA;
    endcase
    return d;
  endfunction

  task automatic issue(input logic we, input addr_t a, input data_t d, input be_t be);
    bus_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = a;
    r.wdata = d;
    @(posedge clk);
    master_req <= r;
    exp_name_q.push_back(test_name);
    exp_err_q.push_back(region_of(a) == REG_NONE);
    if (we) begin
      exp_data_q.push_back('0);
      model_write(a, d, be);
    end else begin
      exp_data_q.push_back(model_read(a));
    end
  endtask

  task automatic bus_write(input addr_t a, input data_t d, input be_t be);
    issue(1'b1, a, d, be);
  endtask

  task automatic bus_read(input addr_t a);
    issue(1'b0, a, '0, 4'hF);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      master_req.req <= 1'b0;
    end
  endtask

  // new pin levels, rising edges on enabled low pins become pending
  task automatic set_pins(input gpio_vec_t v);
    @(posedge clk);
    master_req.req <= 1'b0;
    gpio_in        <= v;
    pend_m = pend_m | (intr_vec_t'(v) & ~intr_vec_t'(pins_m) & gpio_ien_m);
    pins_m = v;
  endtask

  task automatic check_value(input string what, input data_t exp, input data_t act);
    checks++;
    assert (act === exp) else begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_outputs();
    @(negedge clk);
    check_value("gpio_o", out_m, gpio_out);
    check_value("gpio_oe_o", oe_m, gpio_oe);
    check_value("exit_valid_o", data_t'(exit_valid_m), data_t'(exit_valid));
    check_value("exit_value_o", exit_value_m, exit_value);
    check_value("irq_fast_o", data_t'(|(pend_m & en_m)), data_t'(irq_fast));
  endtask

  // responses are checked where they are stable, between rising edges
  always @(negedge clk) begin
    if (rst) begin
      accept_prev = 1'b0;
    end else begin
      checks++;
      assert (master_rsp.rvalid === accept_prev) else begin
        $display("%s: rvalid was %b but a request %s accepted one cycle before", test_name,
                 master_rsp.rvalid, accept_prev ? "was" : "was not");
        errors++;
      end
      if (master_rsp.rvalid === 1'b1 && exp_data_q.size() != 0) begin
        got_exp  = exp_data_q.pop_front();
        got_err  = exp_err_q.pop_front();
        got_name = exp_name_q.pop_front();
        checks++;
        assert (master_rsp.rdata === got_exp) else begin
          $display("Mismatch in %s, rdata: expected %h, actual %h", got_name, got_exp,
                   master_rsp.rdata);
          errors++;
        end
        assert (master_rsp.err === got_err) else begin
          $display("Mismatch in %s, err: expected %b, actual %b", got_name, got_err,
                   master_rsp.err);
          errors++;
        end
      end
      accept_prev = master_req.req && master_rsp.gnt;
    end
  end

  task automatic start_test(input string name);
    test_name     = name;
    errs_at_start = errors;
  endtask

  task automatic finish_test();
    int waited;
    idle(2);
    waited = 0;
    while (exp_data_q.size() != 0 && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    assert (exp_data_q.size() == 0) else begin
      $display("%s: %0d responses never arrived", test_name, exp_data_q.size());
      errors++;
    end
    tests_run++;
    if (errors == errs_at_start) begin
      $display("%-12s ok", test_name);
    end else begin
      tests_failed++;
      $display("%-12s FAILED with %0d errors", test_name, errors - errs_at_start);
    end
  endtask

  task automatic test_reset();
    logic got_gnt;
    start_test("reset");
    repeat (2) @(posedge clk);
    check_outputs();
    check_value("gnt in reset", '0, data_t'(master_rsp.gnt));
    check_value("rvalid in reset", '0, data_t'(master_rsp.rvalid));
    @(posedge clk);
    rst <= 1'b0;
    got_gnt = 1'b0;
    for (int i = 0; i < 8 && !got_gnt; i++) begin
      @(negedge clk);
      got_gnt = master_rsp.gnt;
    end
    assert (got_gnt) else begin
      $display("%s: gnt never rose after reset", test_name);
      errors++;
    end
    bus_read(GPIO_START + GPIO_OUT_OFF);
    bus_read(AO_START + EXIT_VALID_OFF);
    bus_read(AO_START + INTR_PENDING_OFF);
    finish_test();
  endtask

  task automatic test_ram();
    int w;
    start_test("ram_random");
    // full words first so no byte is left undefined
    for (int i = 0; i < RAM_WORDS; i++)
      bus_write(RAM_START + addr_t'(i * 4), $urandom, 4'hF);
    for (int n = 0; n < RAM_OPS; n++) begin
      w = $urandom_range(RAM_WORDS - 1, 0);
      if ($urandom_range(1, 0) == 1)
        bus_write(RAM_START + addr_t'(w * 4), $urandom, be_t'($urandom));
      else
        bus_read(RAM_START + addr_t'(w * 4));
    end
    finish_test();
  endtask

  task automatic test_gpio_io();
    start_test("gpio_io");
    for (int n = 0; n < GPIO_ROUNDS; n++) begin
      bus_write(GPIO_START + GPIO_OUT_OFF, $urandom, be_t'($urandom));
      bus_write(GPIO_START + GPIO_OE_OFF, $urandom, 4'hF);
      set_pins($urandom);
      idle(4);
      check_outputs();
      bus_read(GPIO_START + GPIO_IN_OFF);
      bus_read(GPIO_START + GPIO_OUT_OFF);
    end
    finish_test();
  endtask

  task automatic test_gpio_irq();
    start_test("gpio_irq");
    for (int n = 0; n < IRQ_ROUNDS; n++) begin
      set_pins(pins_m & 32'hFFFF_FF00);
      idle(4);
      bus_write(GPIO_START + GPIO_INTR_EN_OFF, $urandom, 4'hF);
      bus_write(AO_START + INTR_ENABLE_OFF, $urandom, 4'hF);
      set_pins((pins_m & 32'hFFFF_FF00) | ($urandom & 32'h0000_00FF));
      idle(4);
      check_outputs();
      bus_read(AO_START + INTR_PENDING_OFF);
      bus_write(AO_START + INTR_PENDING_OFF, $urandom, 4'hF);
      idle(1);
      check_outputs();
      bus_read(AO_START + INTR_PENDING_OFF);
    end
    finish_test();
  endtask

  task automatic test_exit();
    start_test("exit_regs");
    for (int n = 0; n < EXIT_ROUNDS; n++) begin
      bus_write(AO_START + EXIT_VALUE_OFF, $urandom, be_t'($urandom));
      bus_write(AO_START + EXIT_VALID_OFF, $urandom, 4'hF);
      idle(1);
      check_outputs();
      bus_read(AO_START + EXIT_VALUE_OFF);
      bus_read(AO_START + EXIT_VALID_OFF);
    end
    finish_test();
  endtask

  task automatic test_unmapped();
    addr_t a;
    start_test("unmapped");
    for (int n = 0; n < UNMAP_OPS; n++) begin
      do
        a = $urandom;
      while (region_of(a) != REG_NONE);
      if ($urandom_range(1, 0) == 1)
        bus_write(a, $urandom, be_t'($urandom));
      else
        bus_read(a);
    end
    idle(1);
    check_outputs();
    bus_read(GPIO_START + GPIO_OUT_OFF);
    bus_read(GPIO_START + GPIO_OE_OFF);
    bus_read(AO_START + EXIT_VALUE_OFF);
    bus_read(AO_START + INTR_ENABLE_OFF);
    bus_read(AO_START + INTR_PENDING_OFF);
    for (int i = 0; i < 8; i++)
      bus_read(RAM_START + addr_t'($urandom_range(RAM_WORDS - 1, 0) * 4));
    finish_test();
  endtask

  initial begin
    #((RUN_CYCLES + 100) * CLK_PERIOD);
    $display("timeout: run did not end within %0d cycles", RUN_CYCLES + 100);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h9610));
    clk          = 1'b0;
    rst          = 1'b1;
    master_req   = '0;
    gpio_in      = '0;
    exit_valid_m = 1'b0;
    exit_value_m = '0;
    pend_m       = '0;
    en_m         = '0;
    gpio_ien_m   = '0;
    out_m        = '0;
    oe_m         = '0;
    pins_m       = '0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    test_reset();
    test_ram();
    test_gpio_io();
    test_gpio_irq();
    test_exit();
    test_unmapped();
    $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
verilog/mcu_pkg.sv
verilog/system_bus.sv
verilog/memory_subsystem.sv
verilog/ao_peripheral_subsystem.sv
verilog/gpio.sv
verilog/mcu_top.sv
test/tb_mcu.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator from sim.f, run it and check the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_mcu -o tb_mcu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_mcu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
exit 1
